// ==== bank_mem.sv ====
// four interleaved word banks, contents start as each word's own address and survive reset
`timescale 1ns/1ns

module bank_mem import mem_pkg::*; #(
   parameter int MEM_LATENCY = 4
) (
   input  logic     clk,
   input  logic     reset,
   input  logic     req,
   input  mem_req_t req_data,
   output logic     ack,
   output data_t    rdata
);

   localparam int ROW_BITS = $bits(word_addr_t) - $bits(word_sel_t);
   localparam int ROWS     = 2 ** ROW_BITS;
   localparam int CW       = $clog2(MEM_LATENCY + 1);

   typedef logic [CW-1:0] busy_cnt_t;

   data_t                mem_bank [WORDS_PER_LINE][ROWS];
   busy_cnt_t            busy_cnt [WORDS_PER_LINE];   // cycles left until the bank is free
   word_sel_t            bank;
   logic [ROW_BITS-1:0]  row;
   logic                 start;

   assign bank  = req_data.addr[1:0];
   assign row   = req_data.addr[14:2];
   assign start = req && !ack && (busy_cnt[bank] == '0);

   initial begin
      for (int b = 0; b < WORDS_PER_LINE; b++) begin
         for (int r = 0; r < ROWS; r++) begin
            mem_bank[b][r] = data_t'(r * WORDS_PER_LINE + b);
         end
      end
   end

   always @(posedge clk) begin
      if (start) begin
         if (req_data.write) begin
            mem_bank[bank][row] <= req_data.wdata;
         end
         rdata <= mem_bank[bank][row];   // old word on a write
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         ack <= 1'b0;
         for (int b = 0; b < WORDS_PER_LINE; b++) begin
            busy_cnt[b] <= '0;
         end
      end else begin
         for (int b = 0; b < WORDS_PER_LINE; b++) begin
            if (busy_cnt[b] != '0) begin
               busy_cnt[b] <= busy_cnt[b] - 1'b1;
            end
         end
         if (start) begin
            ack            <= 1'b1;
            busy_cnt[bank] <= busy_cnt_t'(MEM_LATENCY);
         end else if (ack && !req) begin
            ack <= 1'b0;
         end
      end
   end

endmodule

// ==== cache_array.sv ====
// direct-mapped line storage; reads are registered and return the old word on a same-edge write
`timescale 1ns/1ns

module cache_array import mem_pkg::*; (
   input  logic      clk,
   input  logic      reset,
   input  index_t    index,
   input  word_sel_t word,
   input  logic      wr_word,
   input  data_t     wdata,
   input  logic      set_tag,
   input  tag_t      tag_in,
   input  logic      set_dirty,
   output tag_t      rd_tag,
   output logic      rd_valid,
   output logic      rd_dirty,
   output data_t     rdata
);

   localparam int LINES = 2 ** $bits(index_t);

   tag_t  tag_mem  [LINES];
   data_t data_mem [LINES][WORDS_PER_LINE];

   logic [LINES-1:0] valid_bits;
   logic [LINES-1:0] dirty_bits;

   // status bits
   always_ff @(posedge clk) begin
      if (reset) begin
         valid_bits <= '0;
         dirty_bits <= '0;
      end else if (set_tag) begin
         valid_bits[index] <= 1'b1;       // line fill done
         dirty_bits[index] <= set_dirty;
      end else if (set_dirty) begin
         dirty_bits[index] <= 1'b1;
      end
   end

   // tag and word storage
   always_ff @(posedge clk) begin
      if (set_tag) begin
         tag_mem[index] <= tag_in;
      end
      if (wr_word) begin
         data_mem[index][word] <= wdata;
      end
   end

   // registered read of the addressed line
   always_ff @(posedge clk) begin
      rd_tag   <= tag_mem[index];
      rd_valid <= valid_bits[index];
      rd_dirty <= dirty_bits[index];
      rdata    <= data_mem[index][word];
   end

endmodule

// ==== cache_ctrl.sv ====
// write-back, write-allocate port; hit in 2 cycles, miss latency depends on memory traffic
`timescale 1ns/1ns

module cache_ctrl import mem_pkg::*; (
   input  logic      clk,
   input  logic      reset,
   input  logic      req,
   input  cpu_req_t  req_data,
   output logic      ack,
   output cpu_resp_t resp,
   output logic      mem_req,
   output mem_req_t  mem_req_data,
   input  logic      mem_ack,
   input  data_t     mem_rdata
);

   typedef enum logic [2:0] {
      st_idle,
      st_lookup,
      st_write_back,
      st_fill,
      st_respond,
      st_release
   } state_t;

   state_t    state;
   word_sel_t cnt;         // word of the line moved over the memory port
   logic      missed;      // miss taken in this transaction

   tag_t      req_tag;
   index_t    req_index;
   word_sel_t req_word;

   tag_t      rd_tag;
   logic      rd_valid;
   logic      rd_dirty;
   data_t     rdata;

   logic      hit;
   logic      hit_write;
   logic      fill_beat;
   logic      wr_word;
   logic      set_tag;
   word_sel_t arr_word;
   data_t     arr_wdata;

   assign req_tag   = req_data.addr[15:11];
   assign req_index = req_data.addr[10:3];
   assign req_word  = req_data.addr[2:1];

   assign hit       = rd_valid && (rd_tag == req_tag);
   assign hit_write = (state == st_lookup) && hit && req_data.write;
   assign fill_beat = (state == st_fill) && mem_req && mem_ack;  // mem_rdata valid
   assign wr_word   = fill_beat || hit_write;
   assign set_tag   = fill_beat && (cnt == 2'd3);
   assign arr_wdata = (state == st_fill) ? mem_rdata : req_data.wdata;

   // lookup on a miss already reads word 0 for the write-back
   always_comb begin
      case (state)
         st_idle:   arr_word = req_word;
         st_lookup: arr_word = hit ? req_word : cnt;
         default:   arr_word = cnt;
      endcase
   end

   cache_array i_array (
      .clk       (clk),
      .reset     (reset),
      .index     (req_index),
      .word      (arr_word),
      .wr_word   (wr_word),
      .wdata     (arr_wdata),
      .set_tag   (set_tag),
      .tag_in    (req_tag),
      .set_dirty (hit_write),
      .rd_tag    (rd_tag),
      .rd_valid  (rd_valid),
      .rd_dirty  (rd_dirty),
      .rdata     (rdata)
   );

   always_ff @(posedge clk) begin
      if (reset) begin
         state   <= st_idle;
         ack     <= 1'b0;
         mem_req <= 1'b0;
         cnt     <= '0;
         missed  <= 1'b0;
      end else begin
         case (state)
            st_idle: begin
               if (req) begin
                  state <= req_data.addr[0] ? st_respond : st_lookup;
               end
            end
            st_lookup: begin
               if (hit) begin
                  state <= st_respond;
               end else begin
                  missed <= 1'b1;
                  state  <= (rd_valid && rd_dirty) ? st_write_back : st_fill;
               end
            end
            st_write_back, st_fill: begin
               if (!mem_req && !mem_ack) begin
                  mem_req <= 1'b1;
               end else if (mem_req && mem_ack) begin
                  mem_req <= 1'b0;
                  cnt     <= cnt + 2'd1;       // wraps back to 0 after word 3
                  if (cnt == 2'd3) begin
                     // after the fill, go round again through idle to hit
                     state <= (state == st_write_back) ? st_fill : st_idle;
                  end
               end
            end
            st_respond: begin
               ack   <= 1'b1;
               state <= st_release;
            end
            st_release: begin
               if (!req) begin
                  ack    <= 1'b0;
                  missed <= 1'b0;
                  state  <= st_idle;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == st_idle && req && req_data.addr[0]) begin
         resp <= '{rdata: '0, hit: 1'b0, err: 1'b1};
      end
      if (state == st_lookup && hit) begin
         resp <= '{rdata: req_data.write ? req_data.wdata : rdata, hit: !missed, err: 1'b0};
      end
      if (!mem_req && !mem_ack) begin
         if (state == st_write_back) begin
            mem_req_data <= '{addr: {rd_tag, req_index, cnt}, wdata: rdata, write: 1'b1};
         end else begin
            mem_req_data <= '{addr: {req_tag, req_index, cnt}, wdata: rdata, write: 1'b0};
         end
      end
   end

endmodule

// ==== mem_arbiter.sv ====
// round-robin owner of the memory port; grant lasts one full four-phase transaction
`timescale 1ns/1ns

module mem_arbiter import mem_pkg::*; #(
   parameter int N_PORTS = 2
) (
   input  logic               clk,
   input  logic               reset,
   input  logic [N_PORTS-1:0] port_req,
   input  mem_req_t           port_req_data [N_PORTS],
   output logic [N_PORTS-1:0] port_ack,
   output data_t              port_rdata,
   output logic               mem_req,
   output mem_req_t           mem_req_data,
   input  logic               mem_ack,
   input  data_t              mem_rdata
);

   localparam int PW = (N_PORTS > 1) ? $clog2(N_PORTS) : 1;
   typedef logic [PW-1:0] port_idx_t;

   port_idx_t grant_q;
   port_idx_t last_q;     // port served last
   port_idx_t pick;
   port_idx_t sel;
   logic      active_q;
   logic      any_req;

   // nearest requester after the last served port wins
   always_comb begin
      pick    = last_q;
      any_req = 1'b0;
      for (int k = N_PORTS; k >= 1; k--) begin
         if (port_req[(int'(last_q) + k) % N_PORTS]) begin
            pick    = port_idx_t'((int'(last_q) + k) % N_PORTS);
            any_req = 1'b1;
         end
      end
   end

   // first cycle goes straight through on the pick, no added latency
   assign sel          = active_q ? grant_q : pick;
   assign mem_req      = active_q ? port_req[grant_q] : (any_req && !mem_ack);
   assign mem_req_data = port_req_data[sel];
   assign port_rdata   = mem_rdata;           // broadcast

   always_comb begin
      for (int i = 0; i < N_PORTS; i++) begin
         port_ack[i] = active_q && (int'(grant_q) == i) && mem_ack;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         active_q <= 1'b0;
         grant_q  <= '0;
         last_q   <= port_idx_t'(N_PORTS - 1);   // port 0 first
      end else if (!active_q) begin
         if (any_req && !mem_ack) begin
            active_q <= 1'b1;
            grant_q  <= pick;
         end
      end else if (!port_req[grant_q] && !mem_ack) begin
         active_q <= 1'b0;
         last_q   <= grant_q;
      end
   end

endmodule

// ==== mem_pkg.sv ====
// shared types; word accesses only, address bit 0 must be zero, no byte enables
package mem_pkg;

   localparam int WORDS_PER_LINE = 4;   // words per cache line, also the bank count

   typedef logic [15:0] addr_t;        // byte address
   typedef logic [15:0] data_t;
   typedef logic [4:0]  tag_t;         // addr[15:11]
   typedef logic [7:0]  index_t;       // addr[10:3]
   typedef logic [1:0]  word_sel_t;    // addr[2:1], picks the bank as well
   typedef logic [14:0] word_addr_t;   // addr[15:1]

   // processor side request, held stable while req is high
   typedef struct packed {
      addr_t addr;
      data_t wdata;
      logic  write;
   } cpu_req_t;

   typedef struct packed {
      data_t rdata;
      logic  hit;      // low when the access needed a line fill
      logic  err;      // odd address, nothing was done
   } cpu_resp_t;

   // one word per memory transaction
   typedef struct packed {
      word_addr_t addr;
      data_t      wdata;
      logic       write;
   } mem_req_t;

endpackage

// ==== mem_system_top.sv ====
// instruction and data caches share one banked memory, no coherence between the two
`timescale 1ns/1ns

module mem_system_top import mem_pkg::*; #(
   parameter int MEM_LATENCY = 4
) (
   input  logic      clk,
   input  logic      reset,
   input  logic      i_req,
   input  cpu_req_t  i_req_data,
   output logic      i_ack,
   output cpu_resp_t i_resp,
   input  logic      d_req,
   input  cpu_req_t  d_req_data,
   output logic      d_ack,
   output cpu_resp_t d_resp
);

   logic [1:0] port_req;           // 0 instruction, 1 data
   mem_req_t   port_req_data [2];
   logic [1:0] port_ack;
   data_t      port_rdata;

   logic       mem_req;
   mem_req_t   mem_req_data;
   logic       mem_ack;
   data_t      mem_rdata;

   cache_ctrl i_icache (
      .clk          (clk),
      .reset        (reset),
      .req          (i_req),
      .req_data     (i_req_data),
      .ack          (i_ack),
      .resp         (i_resp),
      .mem_req      (port_req[0]),
      .mem_req_data (port_req_data[0]),
      .mem_ack      (port_ack[0]),
      .mem_rdata    (port_rdata)
   );

   cache_ctrl i_dcache (
      .clk          (clk),
      .reset        (reset),
      .req          (d_req),
      .req_data     (d_req_data),
      .ack          (d_ack),
      .resp         (d_resp),
      .mem_req      (port_req[1]),
      .mem_req_data (port_req_data[1]),
      .mem_ack      (port_ack[1]),
      .mem_rdata    (port_rdata)
   );

   mem_arbiter #(
      .N_PORTS (2)
   ) i_arbiter (
      .clk           (clk),
      .reset         (reset),
      .port_req      (port_req),
      .port_req_data (port_req_data),
      .port_ack      (port_ack),
      .port_rdata    (port_rdata),
      .mem_req       (mem_req),
      .mem_req_data  (mem_req_data),
      .mem_ack       (mem_ack),
      .mem_rdata     (mem_rdata)
   );

   bank_mem #(
      .MEM_LATENCY (MEM_LATENCY)
   ) i_mem (
      .clk      (clk),
      .reset    (reset),
      .req      (mem_req),
      .req_data (mem_req_data),
      .ack      (mem_ack),
      .rdata    (mem_rdata)
   );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, and decide by searching the log for the fail message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sources.f --top-module tb_mem_system -o vsim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/vsim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Testbench failed" sim.log; then
   exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
   echo "no result found in sim.log"
   exit 1
fi
exit 0

// ==== sources.f ====
+incdir+.
mem_pkg.sv
cache_array.sv
cache_ctrl.sv
mem_arbiter.sv
bank_mem.sv
mem_system_top.sv
tb_mem_system.sv

// ==== tb_checks.svh ====
// included inside tb_mem_system; uses its clk, port signals and err_count, one request per call
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

task automatic check_data(input data_t got, input data_t exp, input string what);
   if (got !== exp) begin
      err_count++;
      $display("ERR %0t ns: %s, data %h, expected %h", $time, what, got, exp);
   end
endtask

task automatic check_hit(input logic got, input logic exp, input string what);
   if (got !== exp) begin
      err_count++;
      $display("ERR %0t ns: %s, hit %b, expected %b", $time, what, got, exp);
   end
endtask

task automatic check_err(input logic got, input logic exp, input string what);
   if (got !== exp) begin
      err_count++;
      $display("ERR %0t ns: %s, err %b, expected %b", $time, what, got, exp);
   end
endtask

// four-phase request on one port, req kept high for hold extra cycles after ack
task automatic issue_request(input logic dport, input cpu_req_t rq, input int hold,
                             output cpu_resp_t rsp);
   @(posedge clk);
   #2;
   if (dport) begin
      d_req_data = rq;
      d_req      = 1'b1;
   end else begin
      i_req_data = rq;
      i_req      = 1'b1;
   end
   do begin
      @(posedge clk);
      #2;
   end while (!(dport ? d_ack : i_ack));
   rsp = dport ? d_resp : i_resp;
   for (int k = 0; k < hold; k++) begin
      @(posedge clk);
      #2;
      if (!(dport ? d_ack : i_ack)) begin
         err_count++;
         $display("ack dropped at %0t ns while req was still held", $time);
      end
   end
   if (dport) begin
      d_req = 1'b0;
   end else begin
      i_req = 1'b0;
   end
   do begin
      @(posedge clk);
      #2;
   end while (dport ? d_ack : i_ack);
endtask

`endif

// ==== tb_mem_system.sv ====
// instruction port stays below 0x8000 and data port above, since the caches are not coherent
`timescale 1ns/1ns

module tb_mem_system import mem_pkg::*;;

   localparam int N_REQ          = 136;             // all requests of all tests
   localparam int TIMEOUT_CYCLES = N_REQ * 80 + 8;  // worst miss per request plus reset

   logic      clk = 1'b0;
   logic      reset;
   logic      i_req;
   cpu_req_t  i_req_data;
   logic      i_ack;
   cpu_resp_t i_resp;
   logic      d_req;
   cpu_req_t  d_req_data;
   logic      d_ack;
   cpu_resp_t d_resp;

   int          err_count    = 0;
   int          tests_run    = 0;
   int          tests_passed = 0;
   int          cycles       = 0;
   logic [15:0] lfsr         = 16'd37;

   data_t model_mem [32768];   // word address pattern at power-up
   logic  valid_m   [2][256];  // per port, 0 instruction
   tag_t  tag_m     [2][256];

   mem_system_top #(
      .MEM_LATENCY (4)
   ) i_dut (
      .clk        (clk),
      .reset      (reset),
      .i_req      (i_req),
      .i_req_data (i_req_data),
      .i_ack      (i_ack),
      .i_resp     (i_resp),
      .d_req      (d_req),
      .d_req_data (d_req_data),
      .d_ack      (d_ack),
      .d_resp     (d_resp)
   );

   `include "tb_checks.svh"

   always #10 clk = ~clk;

   always @(posedge clk) begin
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
         $display("run timed out after %0d cycles, a request never completed", cycles);
         $display("Testbench failed");
         $finish;
      end
   end

   // fibonacci lfsr, taps 16 14 13 11, one step per bit
   function automatic logic [15:0] rand_bits(input int n);
      logic [15:0] r;
      logic        fb;
      r = '0;
      for (int k = 0; k < n; k++) begin
         fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
         lfsr = {lfsr[14:0], fb};
         r    = {r[14:0], fb};
      end
      return r;
   endfunction

   function automatic addr_t make_addr(input tag_t t, input index_t i, input word_sel_t w);
      return {t, i, w, 1'b0};
   endfunction

   // few tags and lines so that hits occur
   function automatic addr_t instr_addr();
      tag_t      t;
      index_t    i;
      word_sel_t w;
      t = tag_t'(rand_bits(2));
      i = index_t'(rand_bits(3));
      w = word_sel_t'(rand_bits(2));
      return make_addr(t, i, w);
   endfunction

   function automatic addr_t data_addr();
      tag_t      t;
      index_t    i;
      word_sel_t w;
      t = tag_t'(rand_bits(2)) | 5'b10000;   // upper half
      i = index_t'(rand_bits(3));
      w = word_sel_t'(rand_bits(2));
      return make_addr(t, i, w);
   endfunction

   task automatic model_access(input logic dport, input cpu_req_t rq, output data_t exp_data,
                               output logic exp_hit, output logic exp_err);
      index_t idx;
      tag_t   tg;
      idx      = rq.addr[10:3];
      tg       = rq.addr[15:11];
      exp_err  = rq.addr[0];
      exp_hit  = 1'b0;
      exp_data = '0;
      if (!exp_err) begin
         exp_hit            = valid_m[dport][idx] && (tag_m[dport][idx] == tg);
         valid_m[dport][idx] = 1'b1;
         tag_m[dport][idx]   = tg;
         if (rq.write) begin
            model_mem[rq.addr[15:1]] = rq.wdata;
         end
         exp_data = model_mem[rq.addr[15:1]];
      end
   endtask

   task automatic run_one(input logic dport, input addr_t addr, input logic write,
                          input data_t wdata, input int hold);
      cpu_req_t  rq;
      cpu_resp_t rsp;
      data_t     exp_data;
      logic      exp_hit;
      logic      exp_err;
      string     what;
      rq   = '{addr: addr, wdata: wdata, write: write};
      what = $sformatf("%s port %s %h", dport ? "d" : "i", write ? "write" : "read", addr);
      model_access(dport, rq, exp_data, exp_hit, exp_err);
      issue_request(dport, rq, hold, rsp);
      check_err(rsp.err, exp_err, what);
      if (!exp_err) begin
         check_hit(rsp.hit, exp_hit, what);
         check_data(rsp.rdata, exp_data, what);
      end
   endtask

   task automatic finish_test(input string name, input int errs_before);
      tests_run++;
      if (err_count == errs_before) begin
         tests_passed++;
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d errors", name, err_count - errs_before);
      end
   endtask

   initial begin
      addr_t ia;
      addr_t da;
      logic  wr;
      data_t wd;
      int    eb;
      reset      = 1'b1;
      i_req      = 1'b0;
      d_req      = 1'b0;
      i_req_data = '0;
      d_req_data = '0;
      for (int a = 0; a < 32768; a++) begin
         model_mem[a] = data_t'(a);
      end
      for (int p = 0; p < 2; p++) begin
         for (int l = 0; l < 256; l++) begin
            valid_m[p][l] = 1'b0;
            tag_m[p][l]   = '0;
         end
      end
      repeat (8) @(posedge clk);
      #2;
      reset = 1'b0;

      eb = err_count;
      for (int n = 0; n < 40; n++) begin
         run_one(1'b0, instr_addr(), 1'b0, '0, 0);
      end
      finish_test("instruction reads", eb);

      eb = err_count;
      for (int n = 0; n < 8; n++) begin
         da = data_addr();
         wd = data_t'(rand_bits(16));
         run_one(1'b1, da, 1'b1, wd, 0);
         run_one(1'b1, da, 1'b0, '0, 0);
      end
      finish_test("write then read", eb);

      // same lines, other tag, so dirty victims go back to memory
      eb = err_count;
      for (int k = 0; k < 4; k++) begin
         wd = data_t'(rand_bits(16));
         run_one(1'b1, make_addr(5'b11000, index_t'(8'h40 + k), word_sel_t'(k)), 1'b1, wd, 0);
      end
      for (int k = 0; k < 4; k++) begin
         run_one(1'b1, make_addr(5'b11001, index_t'(8'h40 + k), word_sel_t'(k)), 1'b0, '0, 0);
      end
      for (int k = 0; k < 4; k++) begin
         run_one(1'b1, make_addr(5'b11000, index_t'(8'h40 + k), word_sel_t'(k)), 1'b0, '0, 0);
      end
      finish_test("dirty eviction", eb);

      eb = err_count;
      run_one(1'b0, 16'h0123, 1'b0, '0, 0);
      run_one(1'b0, 16'h0122, 1'b0, '0, 0);
      run_one(1'b1, 16'h8457, 1'b1, 16'hdead, 0);
      run_one(1'b1, 16'h8456, 1'b0, '0, 0);
      finish_test("odd address", eb);

      eb = err_count;
      for (int n = 0; n < 30; n++) begin
         ia = instr_addr();
         da = data_addr();
         wr = (rand_bits(1) != 0);
         wd = data_t'(rand_bits(16));
         fork
            run_one(1'b0, ia, 1'b0, '0, 0);
            run_one(1'b1, da, wr, wd, 0);
         join
      end
      finish_test("both ports", eb);

      eb = err_count;
      run_one(1'b1, data_addr(), 1'b0, '0, 5);
      run_one(1'b1, data_addr(), 1'b0, '0, 0);
      run_one(1'b0, instr_addr(), 1'b0, '0, 5);
      run_one(1'b0, instr_addr(), 1'b0, '0, 0);
      finish_test("held request", eb);

      $display("%0d of %0d tests passed, %0d errors", tests_passed, tests_run, err_count);
      if (err_count == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule
